// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= tb_wb_line_ram
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test FAILED

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+verilog
verilog/wbram_pkg.sv
verilog/wb_req_decode.sv
verilog/line_ram.sv
verilog/burst_resp.sv
verilog/wb_line_ram.sv
verification/tb_wb_line_ram.sv

// File: verification/tb_wb_line_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "wbram_settings.svh"

module tb_wb_line_ram
  import wbram_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int LAT        = `WBRAM_LATENCY;
  localparam int LWORDS     = `WBRAM_LINE_WORDS;
  localparam int N_LINES    = `WBRAM_DEPTH_LINES;
  localparam int N_WORDS    = N_LINES * LWORDS;
  localparam int WIDX_W     = $clog2(N_WORDS);
  // Cycles a request may wait before it counts as lost
  localparam int RESP_LIMIT = LAT + 4;
  localparam logic [31:0] SEED = 32'h6d1836dd;

  // ====================
  // Run length
  // ====================
  localparam int N_RW    = 40;
  localparam int N_BURST = 30;
  localparam int N_ERR   = 20;
  localparam int N_MIX   = 20;
  // Fill and sweep cover every word once
  localparam int N_TXN   = 2 * N_WORDS + 2 * N_RW + N_BURST + N_ERR + 4 * N_MIX;
  localparam int WATCHDOG_CYCLES = N_TXN * (LAT + 8) + 200;

  logic    clk_i = 1'b0;
  logic    rst_ni;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  // Reference memory with one entry per bus word
  word_t model [N_WORDS];
  int    n_errors = 0;
  int    n_checks = 0;

  wb_line_ram u_dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // ====================
  // Helpers
  // ====================
  // Initial contents depend on every address bit
  function automatic word_t fill_word(input bus_addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  // Byte select rule of a Wishbone write
  function automatic word_t merge_sel(input word_t old_w, input word_t new_w, input sel_t sel);
    word_t res;
    res = old_w;
    for (int b = 0; b < $bits(sel_t); b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $urandom % n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One beat sampled at the falling edge
  // Cycle 0 is the request cycle
  task automatic bus_cycle(input bus_addr_t adr, input logic we, input word_t dat,
                           input sel_t sel, input wb_cti_e cti,
                           output logic got_ack, output logic got_err,
                           output word_t rdata, output int cycles);
    logic done;
    @(posedge clk_i);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= adr;
    wb_req.dat <= dat;
    wb_req.sel <= sel;
    wb_req.cti <= cti;
    cycles  = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdata   = '0;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      // Slave never back-pressures
      check_value("wb_rsp_o.stall", {31'd0, wb_rsp.stall}, 32'd0);
      if (wb_rsp.ack || wb_rsp.err) begin
        got_ack = wb_rsp.ack;
        got_err = wb_rsp.err;
        rdata   = wb_rsp.dat;
        done    = 1'b1;
      end else if (cycles == RESP_LIMIT) begin
        n_errors++;
        $display("Timeout: no ack or err for the request to address %h", adr);
        done = 1'b1;
      end else begin
        cycles++;
      end
    end
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
    wb_req.cti <= CTI_CLASSIC;
  endtask

  // ====================
  // Transactions
  // ====================
  task automatic write_word(input bus_addr_t adr, input word_t dat, input sel_t sel);
    logic  got_ack;
    logic  got_err;
    word_t rdata;
    int    cycles;
    bus_cycle(adr, 1'b1, dat, sel, CTI_CLASSIC, got_ack, got_err, rdata, cycles);
    check_value("wb_rsp_o.ack on write", {31'd0, got_ack}, 32'd1);
    check_value("wb_rsp_o.err on write", {31'd0, got_err}, 32'd0);
    // Zero wait state write
    check_value("write ack delay", cycles, 32'd0);
    bus_idle();
    model[adr[2 +: WIDX_W]] = merge_sel(model[adr[2 +: WIDX_W]], dat, sel);
  endtask

  // Classic read with the first response exactly on the latency
  task automatic read_check(input bus_addr_t adr);
    logic  got_ack;
    logic  got_err;
    word_t rdata;
    int    cycles;
    bus_cycle(adr, 1'b0, '0, '0, CTI_CLASSIC, got_ack, got_err, rdata, cycles);
    check_value("wb_rsp_o.ack on read", {31'd0, got_ack}, 32'd1);
    check_value("wb_rsp_o.err on read", {31'd0, got_err}, 32'd0);
    check_value("read ack delay", cycles, LAT);
    check_value("wb_rsp_o.dat on read", rdata, model[adr[2 +: WIDX_W]]);
    bus_idle();
  endtask

  // INCR beats then EOB inside one line
  task automatic read_burst(input int lidx, input int start, input int len);
    bus_addr_t adr;
    wb_cti_e   cti;
    logic      got_ack;
    logic      got_err;
    word_t     rdata;
    int        cycles;
    for (int i = 0; i < len; i++) begin
      adr = (lidx * LWORDS + start + i) * 4;
      cti = (i == len - 1) ? CTI_EOB : CTI_INCR;
      bus_cycle(adr, 1'b0, '0, '0, cti, got_ack, got_err, rdata, cycles);
      check_value("wb_rsp_o.ack on burst", {31'd0, got_ack}, 32'd1);
      check_value("wb_rsp_o.err on burst", {31'd0, got_err}, 32'd0);
      // Only the first beat waits for the RAM
      check_value("burst beat delay", cycles, (i == 0) ? LAT : 0);
      check_value("wb_rsp_o.dat on burst", rdata, model[adr[2 +: WIDX_W]]);
    end
    bus_idle();
  endtask

  task automatic random_burst(input int lidx);
    int len;
    int start;
    len   = 2 + int'(rand_below(3));
    start = int'(rand_below(LWORDS - len + 1));
    read_burst(lidx, start, len);
  endtask

  // Out of range access gets err and no late ack
  task automatic error_access(input bus_addr_t adr, input logic we);
    logic  got_ack;
    logic  got_err;
    word_t rdata;
    int    cycles;
    bus_cycle(adr, we, $urandom, '1, CTI_CLASSIC, got_ack, got_err, rdata, cycles);
    check_value("wb_rsp_o.err out of range", {31'd0, got_err}, 32'd1);
    check_value("wb_rsp_o.ack out of range", {31'd0, got_ack}, 32'd0);
    check_value("err delay", cycles, 32'd0);
    bus_idle();
    repeat (LAT + 2) begin
      @(negedge clk_i);
      check_value("wb_rsp_o.ack after err", {31'd0, wb_rsp.ack}, 32'd0);
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    bus_addr_t   adr;
    word_t       dat;
    logic [31:0] r;
    int          lidx;
    int          other;
    void'($urandom(SEED));
    rst_ni <= 1'b0;
    wb_req <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Quiet bus after reset
    repeat (3) begin
      @(negedge clk_i);
      check_value("wb_rsp_o.ack idle", {31'd0, wb_rsp.ack}, 32'd0);
      check_value("wb_rsp_o.err idle", {31'd0, wb_rsp.err}, 32'd0);
      check_value("wb_rsp_o.stall idle", {31'd0, wb_rsp.stall}, 32'd0);
    end

    // Known contents everywhere
    for (int w = 0; w < N_WORDS; w++) begin
      adr = w * 4;
      write_word(adr, fill_word(adr), '1);
    end

    // Partial writes each read straight back
    for (int i = 0; i < N_RW; i++) begin
      r   = $urandom;
      adr = (r % N_WORDS) * 4;
      dat = $urandom;
      r   = $urandom;
      write_word(adr, dat, r[3:0]);
      read_check(adr);
    end

    for (int i = 0; i < N_BURST; i++) begin
      random_burst(int'(rand_below(N_LINES)));
    end

    // Above 1 KiB with both range edges included
    // Bit 10 forces the range
    for (int i = 0; i < N_ERR; i++) begin
      r = $urandom;
      if (i == 0) begin
        adr = 32'h0000_0400;
      end else if (i == 1) begin
        adr = 32'hFFFF_FFFC;
      end else begin
        adr = {r[31:2], 2'b00} | 32'h0000_0400;
      end
      error_access(adr, r[0]);
    end

    // Whole array unchanged by the rejected accesses
    for (int w = 0; w < N_WORDS; w++) begin
      read_check(w * 4);
    end

    // Writes to another line between bursts
    for (int i = 0; i < N_MIX; i++) begin
      lidx  = int'(rand_below(N_LINES));
      other = (lidx + 1 + int'(rand_below(N_LINES - 1))) % N_LINES;
      random_burst(lidx);
      r   = $urandom;
      adr = (other * LWORDS + int'(r[1:0])) * 4;
      dat = $urandom;
      write_word(adr, dat, r[7:4]);
      random_burst(lidx);
      read_burst(other, 0, LWORDS);
    end

    $display("Run complete: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/burst_resp.sv
`timescale 1ns/1ns
`default_nettype none

`include "wbram_settings.svh"

module burst_resp
  import wbram_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wb_req_t   wb_req_i,
  input  logic      req_ok_i,
  input  logic      req_err_i,
  input  word_off_t word_off_i,
  input  logic      is_burst_i,
  input  line_t     rd_data_i,
  input  logic      rd_valid_i,
  output logic      txn_done_o,
  output wb_rsp_t   wb_rsp_o
);

  resp_state_e state_q;
  resp_state_e state_d;
  line_t       buf_q;
  line_t       src_line;
  logic        rd_req;
  logic        wr_ack;
  logic        first_ack;
  logic        go_burst;
  logic        beat_ack;
  logic        last_beat;

  assign rd_req = req_ok_i & ~wb_req_i.we;
  // Writes complete in the request cycle
  assign wr_ack = req_ok_i & wb_req_i.we;

  // First beat, straight from the RAM output
  assign first_ack = (state_q == RESP_WAIT) & rd_valid_i;
  // EOB on the first beat is a one-beat burst
  assign go_burst  = is_burst_i & (wb_req_i.cti != CTI_EOB);

  // Later beats, from the line buffer
  assign beat_ack  = (state_q == RESP_BURST) & rd_req;
  assign last_beat = beat_ack & (wb_req_i.cti == CTI_EOB);

  // ====================
  // Response FSM
  // ====================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RESP_IDLE: begin
        if (rd_req) begin
          state_d = RESP_WAIT;
        end
      end
      RESP_WAIT: begin
        if (rd_valid_i) begin
          state_d = go_burst ? RESP_BURST : RESP_IDLE;
        end
      end
      RESP_BURST: begin
        if (last_beat) begin
          state_d = RESP_IDLE;
        end
      end
      default: state_d = RESP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Re-arms the read issue in decode
  assign txn_done_o = (first_ack & ~go_burst) | last_beat;

  // ====================
  // Line buffer and word select
  // ====================
  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      buf_q <= rd_data_i;
    end
  end

  // Buffer is not loaded yet on the first beat
  assign src_line = (state_q == RESP_WAIT) ? rd_data_i : buf_q;

  // Each beat picks its own word
  assign wb_rsp_o.dat   = src_line[word_off_i*$bits(word_t) +: $bits(word_t)];
  assign wb_rsp_o.ack   = wr_ack | first_ack | beat_ack;
  assign wb_rsp_o.err   = req_err_i;
  // Never back-pressures
  assign wb_rsp_o.stall = 1'b0;

  // Range check and read tracking never overlap
  a_ack_err_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_o.ack && wb_rsp_o.err)
  );

endmodule

`default_nettype wire

// File: verilog/line_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "wbram_settings.svh"

module line_ram
  import wbram_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  ram_wr_t ram_wr_i,
  input  ram_rd_t ram_rd_i,
  output line_t   rd_data_o,
  output logic    rd_valid_o
);

  localparam int LAT    = `WBRAM_LATENCY;
  localparam int LINES  = `WBRAM_DEPTH_LINES;
  localparam int NBYTES = $bits(lstrb_t);

  line_t          mem_q [LINES];
  logic [LAT-1:0] vld_q;
  // Index stages, the last stage reads the array
  line_idx_t      idx_q [LAT-1];
  line_t          data_q;

  // ====================
  // Write port
  // ====================
  // Byte granular update of one line
  always_ff @(posedge clk_i) begin
    if (ram_wr_i.en) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (ram_wr_i.strb[b]) begin
          mem_q[ram_wr_i.idx][b*8 +: 8] <= ram_wr_i.data[b*8 +: 8];
        end
      end
    end
  end

  // ====================
  // Read pipeline
  // ====================
  // Valid bit per latency slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[LAT-2:0], ram_rd_i.issue};
    end
  end

  // Index rides along, line read on the final stage
  always_ff @(posedge clk_i) begin
    idx_q[0] <= ram_rd_i.idx;
    for (int s = 1; s < LAT - 1; s++) begin
      idx_q[s] <= idx_q[s-1];
    end
    data_q <= mem_q[idx_q[LAT-2]];
  end

  assign rd_data_o  = data_q;
  assign rd_valid_o = vld_q[LAT-1];

  // Decode keeps reads and writes apart
  a_no_rw_same_line : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(ram_wr_i.en && ram_rd_i.issue && (ram_wr_i.idx == ram_rd_i.idx))
  );

endmodule

`default_nettype wire

// File: verilog/wb_line_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "wbram_settings.svh"

module wb_line_ram
  import wbram_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  // Decode to RAM
  ram_wr_t   ram_wr;
  ram_rd_t   ram_rd;
  // Decode to response side
  logic      req_ok;
  logic      req_err;
  word_off_t word_off;
  logic      is_burst;
  // Response side back to decode
  logic      txn_done;
  // RAM to response side
  line_t     rd_data;
  logic      rd_valid;

  wb_req_decode u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req_i),
    .txn_done_i (txn_done),
    .ram_wr_o   (ram_wr),
    .ram_rd_o   (ram_rd),
    .req_ok_o   (req_ok),
    .req_err_o  (req_err),
    .word_off_o (word_off),
    .is_burst_o (is_burst)
  );

  line_ram u_ram (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ram_wr_i   (ram_wr),
    .ram_rd_i   (ram_rd),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid)
  );

  burst_resp u_resp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req_i),
    .req_ok_i   (req_ok),
    .req_err_i  (req_err),
    .word_off_i (word_off),
    .is_burst_i (is_burst),
    .rd_data_i  (rd_data),
    .rd_valid_i (rd_valid),
    .txn_done_o (txn_done),
    .wb_rsp_o   (wb_rsp_o)
  );

endmodule

`default_nettype wire

// File: verilog/wb_req_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "wbram_settings.svh"

module wb_req_decode
  import wbram_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wb_req_t   wb_req_i,
  input  logic      txn_done_i,
  output ram_wr_t   ram_wr_o,
  output ram_rd_t   ram_rd_o,
  output logic      req_ok_o,
  output logic      req_err_o,
  output word_off_t word_off_o,
  output logic      is_burst_o
);

  // Byte address split: | line index | word offset | byte |
  localparam int OFF_LSB = $clog2(`WBRAM_WORD_W / 8);
  localparam int IDX_LSB = OFF_LSB + $bits(word_off_t);
  // First byte past the array
  localparam bus_addr_t RAM_BYTES =
    bus_addr_t'(`WBRAM_DEPTH_LINES * `WBRAM_LINE_WORDS * `WBRAM_WORD_W / 8);

  logic      req;
  logic      in_range;
  logic      wr_en;
  logic      issue;
  logic      issued_q;
  line_idx_t line_idx;
  word_off_t word_off;
  lstrb_t    wr_strb;

  assign req      = wb_req_i.cyc & wb_req_i.stb;
  assign in_range = wb_req_i.adr < RAM_BYTES;
  assign line_idx = wb_req_i.adr[IDX_LSB +: $bits(line_idx_t)];
  assign word_off = wb_req_i.adr[OFF_LSB +: $bits(word_off_t)];

  assign req_ok_o   = req & in_range;
  // Out of range answers with err, never aliases
  assign req_err_o  = req & ~in_range;
  assign word_off_o = word_off;
  assign is_burst_o = (wb_req_i.cti == CTI_INCR) || (wb_req_i.cti == CTI_EOB);

  // ====================
  // Line write
  // ====================
  assign wr_en = req_ok_o & wb_req_i.we;

  // Selects land on the addressed word only
  always_comb begin
    wr_strb = '0;
    if (wr_en) begin
      wr_strb[word_off*$bits(sel_t) +: $bits(sel_t)] = wb_req_i.sel;
    end
  end

  assign ram_wr_o.en   = wr_en;
  assign ram_wr_o.idx  = line_idx;
  // Same word in every slot, strobes pick one
  assign ram_wr_o.data = {`WBRAM_LINE_WORDS{wb_req_i.dat}};
  assign ram_wr_o.strb = wr_strb;

  // ====================
  // Line read
  // ====================
  // One issue per transaction
  assign issue = req_ok_o & ~wb_req_i.we & ~issued_q;

  assign ram_rd_o.issue = issue;
  assign ram_rd_o.idx   = line_idx;

  // Held from issue until the last beat is acked
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= 1'b0;
    end else if (txn_done_i) begin
      issued_q <= 1'b0;
    end else if (issue) begin
      issued_q <= 1'b1;
    end
  end

  // Done never follows issue directly, so no back-to-back issue
  a_single_issue : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue |=> !issue
  );

endmodule

`default_nettype wire

// File: verilog/wbram_pkg.sv
`default_nettype none

`include "wbram_settings.svh"

package wbram_pkg;

  // ====================
  // Widths with a meaning
  // ====================
  typedef logic [`WBRAM_WORD_W-1:0] word_t;
  typedef logic [`WBRAM_WORD_W/8-1:0] sel_t;
  typedef logic [`WBRAM_WORD_W*`WBRAM_LINE_WORDS-1:0] line_t;
  typedef logic [`WBRAM_WORD_W*`WBRAM_LINE_WORDS/8-1:0] lstrb_t;
  typedef logic [$clog2(`WBRAM_DEPTH_LINES)-1:0] line_idx_t;
  typedef logic [$clog2(`WBRAM_LINE_WORDS)-1:0] word_off_t;
  typedef logic [31:0] bus_addr_t;

  // Wishbone cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = `WBRAM_CTI_CLASSIC,
    CTI_INCR    = `WBRAM_CTI_INCR,
    CTI_EOB     = `WBRAM_CTI_EOB
  } wb_cti_e;

  // Response FSM
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_WAIT,
    RESP_BURST
  } resp_state_e;

  // ====================
  // Bus and RAM bundles
  // ====================
  // Master to slave
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    bus_addr_t adr;
    word_t     dat;
    sel_t      sel;
    wb_cti_e   cti;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic  ack;
    logic  err;
    logic  stall;
    word_t dat;
  } wb_rsp_t;

  // Byte-strobed line write
  typedef struct packed {
    logic      en;
    line_idx_t idx;
    line_t     data;
    lstrb_t    strb;
  } ram_wr_t;

  // Line read issue
  typedef struct packed {
    logic      issue;
    line_idx_t idx;
  } ram_rd_t;

endpackage

`default_nettype wire

// File: verilog/wbram_settings.svh
`ifndef WBRAM_SETTINGS_SVH
`define WBRAM_SETTINGS_SVH

// ====================
// RAM geometry
// ====================

// Bus word width in bits
`define WBRAM_WORD_W 32
// Words per RAM line
`define WBRAM_LINE_WORDS 4
// Lines in the array, 1 KiB overall
`define WBRAM_DEPTH_LINES 64
// Cycles from read issue to line data
`define WBRAM_LATENCY 4

// ====================
// Wishbone burst codes
// ====================

// Classic cycle, incrementing burst, end of burst
`define WBRAM_CTI_CLASSIC 3'd0
`define WBRAM_CTI_INCR 3'd2
`define WBRAM_CTI_EOB 3'd7

`endif
